// File: tag_pkg.sv
`default_nettype none

package tag_pkg;

  //////////////////////////////
  // Trace word layout
  //////////////////////////////

  localparam int TRACE_WIDTH = 16;
  localparam int OP_WIDTH    = 2;

  // Opcodes, same position in every view
  localparam logic [OP_WIDTH-1:0] OP_NOP    = 2'd0;
  localparam logic [OP_WIDTH-1:0] OP_SEND   = 2'd1;
  localparam logic [OP_WIDTH-1:0] OP_WAIT   = 2'd2;
  localparam logic [OP_WIDTH-1:0] OP_FINISH = 2'd3;

  //////////////////////////////
  // Tag packet
  //////////////////////////////

  localparam int TAG_ID_WIDTH      = 3;
  localparam int TAG_PAYLOAD_WIDTH = 8;

  // Id, reset bit, payload
  localparam int PACKET_LEN = TAG_ID_WIDTH + 1 + TAG_PAYLOAD_WIDTH;

  localparam int WAIT_WIDTH = TRACE_WIDTH - OP_WIDTH;

  typedef union packed {
    // Send entry
    struct packed {
      logic [OP_WIDTH-1:0]                      op;
      logic [TAG_ID_WIDTH-1:0]                  id;
      logic                                     rst;
      logic [TAG_PAYLOAD_WIDTH-1:0]             payload;
      logic [TRACE_WIDTH-OP_WIDTH-PACKET_LEN-1:0] spare;
    } send;
    // Wait entry
    struct packed {
      logic [OP_WIDTH-1:0]   op;
      logic [WAIT_WIDTH-1:0] count;
    } delay;
  } tag_trace_word_u;

endpackage

`default_nettype wire

// File: tag_trace_intake.sv
`timescale 1ns/10ps
`default_nettype none

module tag_trace_intake (
  input  wire                       clk,
  input  wire                       arst_n_i,
  input  wire                       trace_req_i,
  input  wire tag_pkg::tag_trace_word_u trace_word_i,
  output logic                      trace_ack_o,
  output logic                      entry_valid_o,
  output tag_pkg::tag_trace_word_u  entry_word_o,
  input  wire                       entry_take_i
);

  logic slot_full_q;
  logic accepted_q;
  logic store;

  // New request, not yet stored, and room for it
  assign store = trace_req_i & ~accepted_q & ~slot_full_q;

  //////////////////////////////
  // Handshake and slot state
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_full_q <= 1'b0;
      accepted_q  <= 1'b0;
    end else begin
      // Hold ack until the host drops req
      if (accepted_q) begin
        if (!trace_req_i) accepted_q <= 1'b0;
      end else if (store) begin
        accepted_q <= 1'b1;
      end

      if (store) begin
        slot_full_q <= 1'b1;
      end else if (entry_take_i) begin
        slot_full_q <= 1'b0;
      end
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (store) entry_word_o <= trace_word_i;
  end

  assign trace_ack_o   = accepted_q;
  assign entry_valid_o = slot_full_q;

  // Ack only ever answers a request seen on the previous edge
  a_ack_follows_req: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    $rose(trace_ack_o) |-> $past(trace_req_i)
  ) else $error("trace_ack_o rose without trace_req_i");

endmodule

`default_nettype wire

// File: tag_trace_replay.sv
`timescale 1ns/10ps
`default_nettype none

module tag_trace_replay (
  input  wire                       clk,
  input  wire                       arst_n_i,
  input  wire                       entry_valid_i,
  input  wire tag_pkg::tag_trace_word_u entry_word_i,
  output logic                      entry_take_o,
  output logic                      tag_en_o,
  output logic                      tag_data_o,
  output logic                      done_o
);

  localparam int CNT_WIDTH = $clog2(tag_pkg::PACKET_LEN);
  localparam logic [CNT_WIDTH-1:0] LAST_BIT = CNT_WIDTH'(tag_pkg::PACKET_LEN - 1);

  logic                            sending_q;
  logic [CNT_WIDTH-1:0]            bits_left_q;
  logic [tag_pkg::PACKET_LEN-1:0]  shift_q;
  logic [tag_pkg::WAIT_WIDTH-1:0]  wait_cnt_q;
  logic                            done_q;

  logic                            busy;
  logic                            take;
  logic                            start_send;
  logic [tag_pkg::OP_WIDTH-1:0]    op;

  //////////////////////////////
  // Entry decode
  //////////////////////////////

  // Opcode field is shared by both views
  assign op = entry_word_i.send.op;

  assign busy       = sending_q | (wait_cnt_q != '0);
  assign take       = entry_valid_i & ~busy;
  assign start_send = take & ~done_q & (op == tag_pkg::OP_SEND);

  //////////////////////////////
  // Sequencing
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sending_q   <= 1'b0;
      bits_left_q <= '0;
      wait_cnt_q  <= '0;
      done_q      <= 1'b0;
    end else begin
      if (sending_q) begin
        if (bits_left_q == '0) begin
          sending_q <= 1'b0;
        end else begin
          bits_left_q <= bits_left_q - 1'b1;
        end
      end else if (wait_cnt_q != '0) begin
        wait_cnt_q <= wait_cnt_q - 1'b1;
      end else if (take && !done_q) begin
        case (op)
          tag_pkg::OP_SEND: begin
            sending_q   <= 1'b1;
            bits_left_q <= LAST_BIT;
          end
          tag_pkg::OP_WAIT: begin
            wait_cnt_q <= entry_word_i.delay.count;
          end
          tag_pkg::OP_FINISH: begin
            done_q <= 1'b1;
          end
          // NOP is taken and dropped
          default: begin
          end
        endcase
      end
    end
  end

  // Packet shifter, MSB leaves first
  always_ff @(posedge clk) begin
    if (start_send) begin
      shift_q <= {entry_word_i.send.id, entry_word_i.send.rst, entry_word_i.send.payload};
    end else if (sending_q) begin
      shift_q <= {shift_q[tag_pkg::PACKET_LEN-2:0], 1'b0};
    end
  end

  assign entry_take_o = take;
  assign tag_en_o     = sending_q;
  assign tag_data_o   = sending_q & shift_q[tag_pkg::PACKET_LEN-1];
  assign done_o       = done_q;

  // Nothing goes out on the tag line once programming has ended
  a_quiet_after_done: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !(tag_en_o && done_o)
  ) else $error("tag_en_o high after done_o");

endmodule

`default_nettype wire

// File: tag_master.sv
`timescale 1ns/10ps
`default_nettype none

module tag_master (
  input  wire                                   clk,
  input  wire                                   arst_n_i,
  input  wire                                   tag_en_i,
  input  wire                                   tag_data_i,
  output logic                                  wr_valid_o,
  output logic [tag_pkg::TAG_ID_WIDTH-1:0]      wr_id_o,
  output logic                                  wr_reset_o,
  output logic [tag_pkg::TAG_PAYLOAD_WIDTH-1:0] wr_payload_o
);

  localparam int CNT_WIDTH = $clog2(tag_pkg::PACKET_LEN);
  localparam logic [CNT_WIDTH-1:0] LAST_BIT = CNT_WIDTH'(tag_pkg::PACKET_LEN - 1);

  logic [tag_pkg::PACKET_LEN-2:0] shift_q;
  logic [CNT_WIDTH-1:0]           bit_cnt_q;
  logic [tag_pkg::PACKET_LEN-1:0] packet;
  logic                           last_bit;

  // Full packet as seen during its final bit
  assign packet   = {shift_q, tag_data_i};
  assign last_bit = tag_en_i & (bit_cnt_q == LAST_BIT);

  //////////////////////////////
  // Bit counter
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q  <= '0;
      wr_valid_o <= 1'b0;
    end else begin
      wr_valid_o <= last_bit;
      if (!tag_en_i || last_bit) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Deserializer
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (tag_en_i) shift_q <= packet[tag_pkg::PACKET_LEN-2:0];

    // Split into fields on the last bit
    if (last_bit) begin
      wr_id_o      <= packet[tag_pkg::PACKET_LEN-1 -: tag_pkg::TAG_ID_WIDTH];
      wr_reset_o   <= packet[tag_pkg::TAG_PAYLOAD_WIDTH];
      wr_payload_o <= packet[tag_pkg::TAG_PAYLOAD_WIDTH-1:0];
    end
  end

  // Enable drops only once a whole packet has arrived
  a_whole_packets: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    $fell(tag_en_i) |-> (bit_cnt_q == '0)
  ) else $error("tag_en_i fell in the middle of a packet");

endmodule

`default_nettype wire

// File: tag_client_bank.sv
`timescale 1ns/10ps
`default_nettype none

module tag_client_bank #(
  parameter int NUM_CLIENTS = 6
) (
  input  wire                                                clk,
  input  wire                                                arst_n_i,
  input  wire                                                wr_valid_i,
  input  wire  [tag_pkg::TAG_ID_WIDTH-1:0]                   wr_id_i,
  input  wire                                                wr_reset_i,
  input  wire  [tag_pkg::TAG_PAYLOAD_WIDTH-1:0]              wr_payload_i,
  output logic [NUM_CLIENTS*tag_pkg::TAG_PAYLOAD_WIDTH-1:0]  client_data_o
);

  logic [NUM_CLIENTS-1:0][tag_pkg::TAG_PAYLOAD_WIDTH-1:0] client_q;

  //////////////////////////////
  // Client registers
  //////////////////////////////

  // Ids past the last client match no entry and are dropped
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      client_q <= '0;
    end else if (wr_valid_i) begin
      for (int i = 0; i < NUM_CLIENTS; i++) begin
        if (int'(wr_id_i) == i) begin
          if (wr_reset_i) begin
            client_q[i] <= '0;
          end else begin
            client_q[i] <= wr_payload_i;
          end
        end
      end
    end
  end

  // Client 0 in the low byte
  assign client_data_o = client_q;

  // Write id comes from the deserializer and must be fully known
  a_known_id: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    wr_valid_i |-> !$isunknown(wr_id_i)
  ) else $error("wr_id_i unknown on a write");

endmodule

`default_nettype wire

// File: clock_downsample.sv
`timescale 1ns/10ps
`default_nettype none

module clock_downsample #(
  parameter int SLOWDOWN_RATIO = 8
) (
  input  wire  clk,
  input  wire  arst_n_i,
  input  wire  slow_i,
  output logic clk_r_o
);

  localparam int CNT_WIDTH = $clog2(SLOWDOWN_RATIO);
  localparam logic [CNT_WIDTH-1:0] SLOW_LIMIT = CNT_WIDTH'(SLOWDOWN_RATIO - 1);

  logic [CNT_WIDTH-1:0] cnt_q;
  logic                 reload;

  assign reload = (cnt_q == '0);

  //////////////////////////////
  // Divider
  //////////////////////////////

  // Rate is picked up only at a reload, so every phase runs to its full length
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q   <= SLOW_LIMIT;
      clk_r_o <= 1'b0;
    end else if (reload) begin
      clk_r_o <= ~clk_r_o;
      if (slow_i) begin
        cnt_q <= SLOW_LIMIT;
      end else begin
        cnt_q <= '0;
      end
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tag_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module tag_subsystem_top #(
  parameter int NUM_CLIENTS    = 6,
  parameter int SLOWDOWN_RATIO = 8
) (
  input  wire                                                clk,
  input  wire                                                arst_n_i,
  // Host trace port
  input  wire                                                trace_req_i,
  input  wire tag_pkg::tag_trace_word_u                      trace_word_i,
  output logic                                               trace_ack_o,
  // Serial tag line
  output logic                                               tag_en_o,
  output logic                                               tag_data_o,
  output logic                                               done_o,
  output logic [NUM_CLIENTS*tag_pkg::TAG_PAYLOAD_WIDTH-1:0]  client_data_o,
  output logic                                               slow_clk_o
);

  logic                                  entry_valid;
  tag_pkg::tag_trace_word_u              entry_word;
  logic                                  entry_take;

  logic                                  wr_valid;
  logic [tag_pkg::TAG_ID_WIDTH-1:0]      wr_id;
  logic                                  wr_reset;
  logic [tag_pkg::TAG_PAYLOAD_WIDTH-1:0] wr_payload;

  //////////////////////////////
  // Trace path
  //////////////////////////////

  tag_trace_intake u_intake (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .trace_req_i   (trace_req_i),
    .trace_word_i  (trace_word_i),
    .trace_ack_o   (trace_ack_o),
    .entry_valid_o (entry_valid),
    .entry_word_o  (entry_word),
    .entry_take_i  (entry_take)
  );

  tag_trace_replay u_replay (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .entry_valid_i (entry_valid),
    .entry_word_i  (entry_word),
    .entry_take_o  (entry_take),
    .tag_en_o      (tag_en_o),
    .tag_data_o    (tag_data_o),
    .done_o        (done_o)
  );

  //////////////////////////////
  // Tag receive side
  //////////////////////////////

  tag_master u_master (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .tag_en_i     (tag_en_o),
    .tag_data_i   (tag_data_o),
    .wr_valid_o   (wr_valid),
    .wr_id_o      (wr_id),
    .wr_reset_o   (wr_reset),
    .wr_payload_o (wr_payload)
  );

  tag_client_bank #(
    .NUM_CLIENTS (NUM_CLIENTS)
  ) u_clients (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .wr_valid_i    (wr_valid),
    .wr_id_i       (wr_id),
    .wr_reset_i    (wr_reset),
    .wr_payload_i  (wr_payload),
    .client_data_o (client_data_o)
  );

  // Core clock runs slow until programming is done
  clock_downsample #(
    .SLOWDOWN_RATIO (SLOWDOWN_RATIO)
  ) u_downsample (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .slow_i   (~done_o),
    .clk_r_o  (slow_clk_o)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tb_tag_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tag_subsystem;

  localparam int NUM_CLIENTS     = 6;
  localparam int SLOWDOWN_RATIO  = 8;
  localparam int PKT_LEN         = tag_pkg::PACKET_LEN;
  localparam int BYTE_W          = tag_pkg::TAG_PAYLOAD_WIDTH;
  localparam int CLIENT_BITS     = NUM_CLIENTS * BYTE_W;
  localparam int WAIT_COUNT      = 40;
  localparam int NUM_ENTRIES     = 31;
  localparam int MARGIN_CYCLES   = 400;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * (PKT_LEN + 20) + WAIT_COUNT + MARGIN_CYCLES;
  localparam int STEP_LIMIT      = 200;

  logic                     clk;
  logic                     arst_n;
  logic                     trace_req;
  tag_pkg::tag_trace_word_u trace_word;
  logic                     trace_ack;
  logic                     tag_en;
  logic                     tag_data;
  logic                     done;
  logic [CLIENT_BITS-1:0]   client_data;
  logic                     slow_clk;

  // Reference model
  logic [BYTE_W-1:0]  model [NUM_CLIENTS];
  logic [PKT_LEN-1:0] exp_pkt_q [$];

  // Packet monitor state
  logic [PKT_LEN-1:0] pkt_q [$];
  int                 first_q [$];
  int                 last_q [$];
  logic [PKT_LEN-1:0] pkt_shift;
  int                 bit_cnt = 0;
  int                 cycle = 0;
  int                 pkt_seen = 0;
  int                 en_count = 0;
  int                 seed_dummy;

  tb_clock_gen #(
    .PERIOD_NS (40)
  ) u_clk (
    .clk (clk)
  );

  tag_subsystem_top #(
    .NUM_CLIENTS    (NUM_CLIENTS),
    .SLOWDOWN_RATIO (SLOWDOWN_RATIO)
  ) dut (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .trace_req_i   (trace_req),
    .trace_word_i  (trace_word),
    .trace_ack_o   (trace_ack),
    .tag_en_o      (tag_en),
    .tag_data_o    (tag_data),
    .done_o        (done),
    .client_data_o (client_data),
    .slow_clk_o    (slow_clk)
  );

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_eq(input string test, input string what,
                          input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else
      fail_run($sformatf("mismatch %s %s expected %0h actual %0h", test, what, exp, act));
  endtask

  //////////////////////////////
  // Trace words and model
  //////////////////////////////

  function automatic tag_pkg::tag_trace_word_u make_send(input logic [2:0] id,
                                                          input logic rst,
                                                          input logic [7:0] payload);
    tag_pkg::tag_trace_word_u w;
    w.send.op      = tag_pkg::OP_SEND;
    w.send.id      = id;
    w.send.rst     = rst;
    w.send.payload = payload;
    w.send.spare   = '0;
    return w;
  endfunction

  function automatic tag_pkg::tag_trace_word_u make_op(input logic [1:0] op,
                                                        input int count);
    tag_pkg::tag_trace_word_u w;
    w.delay.op    = op;
    w.delay.count = tag_pkg::WAIT_WIDTH'(count);
    return w;
  endfunction

  // Client 0 sits in the low byte
  function automatic logic [CLIENT_BITS-1:0] model_flat();
    logic [CLIENT_BITS-1:0] flat;
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      flat[i*BYTE_W +: BYTE_W] = model[i];
    end
    return flat;
  endfunction

  // Four-phase handshake, starts and ends on a falling edge
  task automatic send_entry(input tag_pkg::tag_trace_word_u word);
    int n;
    trace_word = word;
    trace_req  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (trace_ack !== 1'b1 && n < STEP_LIMIT);
    assert (trace_ack === 1'b1) else fail_run("trace_ack_o never rose for a pending request");
    trace_req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (trace_ack !== 1'b0 && n < STEP_LIMIT);
    assert (trace_ack === 1'b0) else fail_run("trace_ack_o stayed high after the request fell");
  endtask

  task automatic issue_send(input logic [2:0] id, input logic rst, input logic [7:0] payload);
    send_entry(make_send(id, rst, payload));
    exp_pkt_q.push_back({id, rst, payload});
    // Ids past the last client are dropped
    if (int'(id) < NUM_CLIENTS) begin
      model[id] = rst ? '0 : payload;
    end
  endtask

  task automatic drain_and_check(input string test);
    int n;
    logic [PKT_LEN-1:0] exp;
    logic [PKT_LEN-1:0] got;
    n = 0;
    while (pkt_q.size() < exp_pkt_q.size() && n < STEP_LIMIT) begin
      @(negedge clk);
      n++;
    end
    check_eq(test, "packet count", exp_pkt_q.size(), pkt_q.size());
    // Client write lands two cycles after the last bit
    repeat (3) @(negedge clk);
    while (exp_pkt_q.size() > 0) begin
      exp = exp_pkt_q.pop_front();
      got = pkt_q.pop_front();
      check_eq(test, "packet", exp, got);
    end
    check_eq(test, "clients", model_flat(), client_data);
  endtask

  task automatic check_toggle_period(input string test, input int expected);
    logic prev;
    int n;
    prev = slow_clk;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (slow_clk === prev && n < 2 * SLOWDOWN_RATIO + 2);
    assert (slow_clk !== prev) else fail_run("slow_clk_o did not toggle");
    for (int k = 0; k < 3; k++) begin
      prev = slow_clk;
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (slow_clk === prev && n < 2 * SLOWDOWN_RATIO + 2);
      check_eq(test, "slow_clk_o half period", expected, n);
    end
  endtask

  //////////////////////////////
  // Packet monitor
  //////////////////////////////

  always @(negedge clk) begin
    cycle++;
    if (arst_n !== 1'b1) begin
      bit_cnt = 0;
    end else if (tag_en === 1'b1) begin
      en_count++;
      if (bit_cnt == 0) first_q.push_back(cycle);
      pkt_shift = {pkt_shift[PKT_LEN-2:0], tag_data};
      bit_cnt++;
      if (bit_cnt == PKT_LEN) begin
        pkt_q.push_back(pkt_shift);
        last_q.push_back(cycle);
        pkt_seen++;
        bit_cnt = 0;
      end
    end else begin
      assert (bit_cnt == 0) else
        fail_run($sformatf("tag_en_o fell after only %0d packet bits", bit_cnt));
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    check_eq("test_reset", "clients", '0, client_data);
    check_eq("test_reset", "done_o", 0, done);
    check_eq("test_reset", "trace_ack_o", 0, trace_ack);
    check_eq("test_reset", "tag_en_o", 0, tag_en);
    check_eq("test_reset", "slow_clk_o", 0, slow_clk);
    check_toggle_period("test_reset", SLOWDOWN_RATIO);
  endtask

  task automatic test_send();
    issue_send(3'($urandom_range(NUM_CLIENTS - 1, 0)), 1'b0, 8'($urandom_range(255, 1)));
    drain_and_check("test_send");
  endtask

  task automatic test_clear_and_range();
    logic [2:0] id;
    id = 3'($urandom_range(NUM_CLIENTS - 1, 0));
    issue_send(id, 1'b0, 8'($urandom_range(255, 1)));
    drain_and_check("test_clear_and_range");
    issue_send(id, 1'b1, 8'($urandom));
    drain_and_check("test_clear_and_range");
    check_eq("test_clear_and_range", "cleared client", 0, client_data[id*BYTE_W +: BYTE_W]);
    // Out of range ids reach the tag line but no client
    issue_send(3'd6, 1'b0, 8'($urandom_range(255, 1)));
    issue_send(3'd7, 1'b0, 8'($urandom_range(255, 1)));
    drain_and_check("test_clear_and_range");
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 20; i++) begin
      issue_send(3'($urandom_range(7, 0)), $urandom_range(3, 0) == 0, 8'($urandom));
    end
    drain_and_check("test_back_to_back");
  endtask

  task automatic test_wait();
    int base;
    int gap;
    base = pkt_seen;
    issue_send(3'($urandom_range(NUM_CLIENTS - 1, 0)), 1'b0, 8'($urandom));
    send_entry(make_op(tag_pkg::OP_WAIT, WAIT_COUNT));
    issue_send(3'($urandom_range(NUM_CLIENTS - 1, 0)), 1'b0, 8'($urandom));
    drain_and_check("test_wait");
    gap = first_q[base + 1] - last_q[base];
    assert (gap >= WAIT_COUNT) else
      fail_run($sformatf("mismatch test_wait gap expected at least %0d actual %0d",
                         WAIT_COUNT, gap));
  endtask

  task automatic test_finish();
    int n;
    int pkts_before;
    int en_before;
    logic [CLIENT_BITS-1:0] clients_before;
    send_entry(make_op(tag_pkg::OP_FINISH, 0));
    n = 0;
    while (done !== 1'b1 && n < STEP_LIMIT) begin
      @(negedge clk);
      n++;
    end
    check_eq("test_finish", "done_o", 1, done);
    pkts_before    = pkt_seen;
    en_before      = en_count;
    clients_before = client_data;
    check_toggle_period("test_finish", 1);
    // Still acked, but dropped by replay
    send_entry(make_send(3'd0, 1'b0, 8'hA5));
    send_entry(make_send(3'd1, 1'b0, 8'h5A));
    repeat (PKT_LEN + 4) @(negedge clk);
    check_eq("test_finish", "packet count", pkts_before, pkt_seen);
    check_eq("test_finish", "tag_en_o cycles", en_before, en_count);
    check_eq("test_finish", "clients", clients_before, client_data);
    check_eq("test_finish", "done_o", 1, done);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed_dummy = $urandom(32'h04f602e7);
    arst_n     = 1'b0;
    trace_req  = 1'b0;
    trace_word = '0;
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      model[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    test_reset();
    test_send();
    test_clear_and_range();
    test_back_to_back();
    test_wait();
    test_finish();

    $display("Result: PASSED");
    $finish;
  end

  // Bound on the whole run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

// File: flist.f
tag_pkg.sv
tag_trace_intake.sv
tag_trace_replay.sv
tag_master.sv
tag_client_bank.sv
clock_downsample.sv
tag_subsystem_top.sv
tb_clock_gen.sv
tb_tag_subsystem.sv

// File: Bender.yml
package:
  name: tag_subsystem

sources:
  - files:
      - tag_pkg.sv
      - tag_trace_intake.sv
      - tag_trace_replay.sv
      - tag_master.sv
      - tag_client_bank.sv
      - clock_downsample.sv
      - tag_subsystem_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_tag_subsystem.sv
